// ==== all.f ====
+incdir+common
common/rv_decode_pkg.sv
source/axil_inst_slave.sv
source/inst_fifo.sv
decoder/inst_decoder.sv
source/rv_decode_top.sv
verification/rv_decode_assert.sv
verification/tb_rv_decode.sv

// ==== common/rv_decode_macros.svh ====
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// instruction word and register file addressing
`define RV_INST_W        32
`define RV_REG_ADDR_W    5

// one bit per byte of a doubleword store
`define RV_STORE_MASK_W  8

// instruction buffer between the bus slave and the decoder
`define RV_FIFO_DEPTH    4

// AXI4-Lite write channel sizes
`define RV_AXIL_ADDR_W   8
`define RV_AXIL_DATA_W   32

// the only SYSTEM encoding the decoder accepts
`define RV_EBREAK_WORD   32'h0010_0073

`endif

// ==== common/rv_decode_pkg.sv ====
`include "rv_decode_macros.svh"

package rv_decode_pkg;

    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_BRANCH    = 7'b1100011,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    // 17 operations, hence 5 bits
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLW,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_IMM_PC,      // auipc
        SRC_FOUR_PC      // link value for jal/jalr
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_sel_e;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_LOAD_W,       // sign extended word
        WB_LOAD_D,
        WB_LOAD_BU,
        WB_IMM           // lui
    } wb_sel_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0]   rd;
        logic [`RV_REG_ADDR_W-1:0]   rs1;
        logic [`RV_REG_ADDR_W-1:0]   rs2;
        logic                        reg_wen;
        logic                        branch;
        logic                        jump;
        logic                        jalr;
        alu_op_e                     alu_op;
        alu_src_e                    alu_src;
        imm_sel_e                    imm_sel;
        wb_sel_e                     wb_sel;
        logic                        store;
        logic [`RV_STORE_MASK_W-1:0] store_mask;
        logic                        word_op;
        logic                        ebreak;
        logic                        illegal;
        logic [`RV_INST_W-1:0]       inst;      // raw word, kept for trace
    } decoded_ctrl_t;

endpackage

// ==== decoder/inst_decoder.sv ====
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module inst_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         empty,
    input  logic [`RV_INST_W-1:0]        head,
    input  logic                         dec_ready,
    output logic                         pop,
    output logic                         dec_valid,
    output rv_decode_pkg::decoded_ctrl_t dec_ctrl
);

    rv_decode_pkg::opcode_e       opcode;
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    logic [5:0]                   funct6;       // RV64 shifts carry a 6 bit shamt
    logic [`RV_REG_ADDR_W-1:0]    rd;
    logic [`RV_REG_ADDR_W-1:0]    rs1;
    logic [`RV_REG_ADDR_W-1:0]    rs2;
    rv_decode_pkg::decoded_ctrl_t d;
    logic                         legal;
    logic                         out_free;

    assign opcode = rv_decode_pkg::opcode_e'(head[6:0]);
    assign funct3 = head[14:12];
    assign funct7 = head[31:25];
    assign funct6 = head[31:26];
    assign rd     = head[11:7];
    assign rs1    = head[19:15];
    assign rs2    = head[24:20];

    always_comb begin
        d       = '0;                           // ALU_ADD, SRC_REG, IMM_I, WB_ALU
        legal   = 1'b1;
        d.inst  = head;
        case (opcode)
            rv_decode_pkg::OPC_OP: begin
                d.rd      = rd;
                d.rs1     = rs1;
                d.rs2     = rs2;
                d.reg_wen = 1'b1;
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) d.alu_op = rv_decode_pkg::ALU_SUB;
                        else legal = (funct7 == 7'b0000000);
                    end
                    3'b111: d.alu_op = rv_decode_pkg::ALU_AND;
                    3'b110: d.alu_op = rv_decode_pkg::ALU_OR;
                    3'b010: d.alu_op = rv_decode_pkg::ALU_SLT;
                    3'b011: d.alu_op = rv_decode_pkg::ALU_SLTU;
                    default: legal = 1'b0;
                endcase
                if (funct3 != 3'b000 && funct7 != 7'b0000000) legal = 1'b0;  // M ops
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                d.rd      = rd;
                d.rs1     = rs1;
                d.reg_wen = 1'b1;
                d.alu_src = rv_decode_pkg::SRC_IMM;
                case (funct3)
                    3'b000: d.alu_op = rv_decode_pkg::ALU_ADD;
                    3'b011: d.alu_op = rv_decode_pkg::ALU_SLTU;
                    3'b100: d.alu_op = rv_decode_pkg::ALU_XOR;
                    3'b111: d.alu_op = rv_decode_pkg::ALU_AND;
                    3'b001: begin
                        d.alu_op  = rv_decode_pkg::ALU_SLL;
                        d.imm_sel = rv_decode_pkg::IMM_SHAMT;
                        legal     = (funct6 == 6'b000000);
                    end
                    3'b101: begin
                        d.imm_sel = rv_decode_pkg::IMM_SHAMT;
                        if (funct6 == 6'b010000) d.alu_op = rv_decode_pkg::ALU_SRA;
                        else d.alu_op = rv_decode_pkg::ALU_SRL;
                        legal = (funct6 == 6'b000000) || (funct6 == 6'b010000);
                    end
                    default: legal = 1'b0;
                endcase
            end
            rv_decode_pkg::OPC_OP_32: begin
                d.rd      = rd;
                d.rs1     = rs1;
                d.rs2     = rs2;
                d.reg_wen = 1'b1;
                d.word_op = 1'b1;
                if (funct3 == 3'b001) d.alu_op = rv_decode_pkg::ALU_SLLW;
                legal = (funct7 == 7'b0000000) && (funct3 == 3'b000 || funct3 == 3'b001);
            end
            rv_decode_pkg::OPC_OP_IMM_32: begin  // addiw only
                d.rd      = rd;
                d.rs1     = rs1;
                d.reg_wen = 1'b1;
                d.word_op = 1'b1;
                d.alu_src = rv_decode_pkg::SRC_IMM;
                legal     = (funct3 == 3'b000);
            end
            rv_decode_pkg::OPC_LOAD: begin
                d.rd      = rd;
                d.rs1     = rs1;
                d.reg_wen = 1'b1;
                d.alu_src = rv_decode_pkg::SRC_IMM;
                case (funct3)
                    3'b010:  d.wb_sel = rv_decode_pkg::WB_LOAD_W;
                    3'b011:  d.wb_sel = rv_decode_pkg::WB_LOAD_D;
                    3'b100:  d.wb_sel = rv_decode_pkg::WB_LOAD_BU;
                    default: legal = 1'b0;
                endcase
            end
            rv_decode_pkg::OPC_STORE: begin
                d.rs1     = rs1;                // address base
                d.rs2     = rs2;
                d.store   = 1'b1;
                d.alu_src = rv_decode_pkg::SRC_IMM;
                d.imm_sel = rv_decode_pkg::IMM_S;
                case (funct3)
                    3'b000:  d.store_mask = 8'h01;
                    3'b001:  d.store_mask = 8'h03;
                    3'b010:  d.store_mask = 8'h0f;
                    3'b011:  d.store_mask = 8'hff;
                    default: legal = 1'b0;
                endcase
            end
            rv_decode_pkg::OPC_JAL: begin
                d.rd      = rd;
                d.reg_wen = 1'b1;
                d.jump    = 1'b1;
                d.alu_src = rv_decode_pkg::SRC_FOUR_PC;
                d.imm_sel = rv_decode_pkg::IMM_J;
            end
            rv_decode_pkg::OPC_JALR: begin
                d.rd      = rd;
                d.rs1     = rs1;
                d.reg_wen = 1'b1;
                d.jump    = 1'b1;
                d.jalr    = 1'b1;
                d.alu_src = rv_decode_pkg::SRC_FOUR_PC;
                legal     = (funct3 == 3'b000);
            end
            rv_decode_pkg::OPC_LUI: begin
                d.rd      = rd;
                d.reg_wen = 1'b1;
                d.alu_src = rv_decode_pkg::SRC_IMM;
                d.imm_sel = rv_decode_pkg::IMM_U;
                d.wb_sel  = rv_decode_pkg::WB_IMM;
            end
            rv_decode_pkg::OPC_AUIPC: begin
                d.rd      = rd;
                d.reg_wen = 1'b1;
                d.alu_src = rv_decode_pkg::SRC_IMM_PC;
                d.imm_sel = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::OPC_BRANCH: begin
                d.rs1     = rs1;
                d.rs2     = rs2;
                d.branch  = 1'b1;
                d.imm_sel = rv_decode_pkg::IMM_B;
                case (funct3)
                    3'b000:  d.alu_op = rv_decode_pkg::ALU_BEQ;
                    3'b001:  d.alu_op = rv_decode_pkg::ALU_BNE;
                    3'b100:  d.alu_op = rv_decode_pkg::ALU_BLT;
                    3'b101:  d.alu_op = rv_decode_pkg::ALU_BGE;
                    3'b110:  d.alu_op = rv_decode_pkg::ALU_BLTU;
                    3'b111:  d.alu_op = rv_decode_pkg::ALU_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            rv_decode_pkg::OPC_SYSTEM: begin
                d.ebreak = (head == `RV_EBREAK_WORD);
                legal    = d.ebreak;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            d         = '0;                     // no enables on a bad word
            d.inst    = head;
            d.illegal = 1'b1;
        end
    end

    assign out_free = ~dec_valid | dec_ready;
    assign pop      = ~empty & out_free;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (out_free) begin
            dec_valid <= ~empty;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_ctrl <= d;                      // held while stalled
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f all.f --top-module tb_rv_decode \
    -o sim_tb_rv_decode
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb_rv_decode)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== source/axil_inst_slave.sv ====
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module axil_inst_slave (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [`RV_AXIL_ADDR_W-1:0]    awaddr,    // not decoded, one target only
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [`RV_AXIL_DATA_W-1:0]    wdata,
    input  logic [`RV_AXIL_DATA_W/8-1:0]  wstrb,
    output logic                          bvalid,
    input  logic                          bready,
    output rv_decode_pkg::axil_resp_e     bresp,
    input  logic                          fifo_full,
    output logic                          push,
    output logic [`RV_INST_W-1:0]         push_data
);

    logic accept;
    logic strb_full;

    // AW and W are taken together, one write per response
    assign accept    = awvalid & wvalid & ~bvalid & ~fifo_full;
    assign awready   = accept;
    assign wready    = accept;

    assign strb_full = &wstrb;                  // partial words are refused
    assign push      = accept & strb_full;
    assign push_data = wdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;                     // master took the response
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bresp <= strb_full ? rv_decode_pkg::RESP_OKAY : rv_decode_pkg::RESP_SLVERR;
        end
    end

endmodule

// ==== source/inst_fifo.sv ====
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module inst_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic [`RV_INST_W-1:0] push_data,
    input  logic                  pop,
    output logic                  full,
    output logic                  empty,
    output logic [`RV_INST_W-1:0] head
);

    localparam int PTR_W = $clog2(`RV_FIFO_DEPTH);

    logic [`RV_INST_W-1:0] mem [`RV_FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;

    assign full  = (count == (PTR_W+1)'(`RV_FIFO_DEPTH));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];                 // first-word fall through

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`RV_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`RV_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== source/rv_decode_top.sv ====
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module rv_decode_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [`RV_AXIL_ADDR_W-1:0]    awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [`RV_AXIL_DATA_W-1:0]    wdata,
    input  logic [`RV_AXIL_DATA_W/8-1:0]  wstrb,
    output logic                          bvalid,
    input  logic                          bready,
    output rv_decode_pkg::axil_resp_e     bresp,
    output logic                          dec_valid,
    input  logic                          dec_ready,
    output rv_decode_pkg::decoded_ctrl_t  dec_ctrl
);

    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  push;
    logic                  pop;
    logic [`RV_INST_W-1:0] push_data;
    logic [`RV_INST_W-1:0] head;

    axil_inst_slave u_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .fifo_full (fifo_full),
        .push      (push),
        .push_data (push_data)
    );

    inst_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .full      (fifo_full),
        .empty     (fifo_empty),
        .head      (head)
    );

    inst_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (fifo_empty),
        .head      (head),
        .dec_ready (dec_ready),
        .pop       (pop),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl)
    );

endmodule

// ==== verification/rv_decode_assert.sv ====
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module rv_decode_assert (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         awready,
    input logic                         bvalid,
    input logic                         bready,
    input logic                         dec_valid,
    input logic                         dec_ready,
    input rv_decode_pkg::decoded_ctrl_t dec_ctrl
);

    // response stays up until the master takes it
    property b_held;
        @(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> bvalid;
    endproperty

    property ctrl_stable;
        @(posedge clk) disable iff (!rst_n)
        (dec_valid && !dec_ready) |=> (dec_valid && $stable(dec_ctrl));
    endproperty

    property no_accept_during_b;
        @(posedge clk) disable iff (!rst_n)
        bvalid |-> !awready;
    endproperty

    a_b_held: assert property (b_held)
        else $error("bvalid dropped before bready");
    a_ctrl_stable: assert property (ctrl_stable)
        else $error("dec_ctrl changed while stalled");
    a_no_accept: assert property (no_accept_during_b)
        else $error("awready high while a response is pending");

endmodule

bind rv_decode_top rv_decode_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .awready   (awready),
    .bvalid    (bvalid),
    .bready    (bready),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_ctrl  (dec_ctrl)
);

// ==== verification/tb_rv_decode.sv ====
`timescale 1ns/100ps
`include "rv_decode_macros.svh"

module tb_rv_decode;

    localparam int n_writes = 120;

    localparam logic [2:0] op_f3_list  [5] = '{3'd0, 3'd7, 3'd6, 3'd2, 3'd3};
    localparam logic [2:0] imm_f3_list [6] = '{3'd0, 3'd3, 3'd4, 3'd7, 3'd1, 3'd5};
    localparam logic [2:0] ld_f3_list  [3] = '{3'd2, 3'd3, 3'd4};
    localparam logic [2:0] br_f3_list  [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic                          clk;
    logic                          rst_n;
    logic                          awvalid;
    logic                          awready;
    logic [`RV_AXIL_ADDR_W-1:0]    awaddr;
    logic                          wvalid;
    logic                          wready;
    logic [`RV_AXIL_DATA_W-1:0]    wdata;
    logic [`RV_AXIL_DATA_W/8-1:0]  wstrb;
    logic                          bvalid;
    logic                          bready;
    rv_decode_pkg::axil_resp_e     bresp;
    logic                          dec_valid;
    logic                          dec_ready;
    rv_decode_pkg::decoded_ctrl_t  dec_ctrl;

    integer                        seed = 91;
    int                            cycle_cnt = 0;
    rv_decode_pkg::decoded_ctrl_t  expected_q [$];

    rv_decode_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic rv_decode_pkg::decoded_ctrl_t ref_decode(input logic [31:0] w);
        rv_decode_pkg::decoded_ctrl_t c;
        logic                         ok;
        logic [2:0]                   f3;
        logic [6:0]                   f7;
        c      = '0;
        ok     = 1'b1;
        f3     = w[14:12];
        f7     = w[31:25];
        c.inst = w;
        case (w[6:0])
            7'b0110011: begin
                {c.rd, c.rs1, c.rs2, c.reg_wen} = {w[11:7], w[19:15], w[24:20], 1'b1};
                if (f7 == 7'h20 && f3 == 3'd0) c.alu_op = rv_decode_pkg::ALU_SUB;
                else if (f7 != 7'h00) ok = 1'b0;
                else if (f3 == 3'd0) c.alu_op = rv_decode_pkg::ALU_ADD;
                else if (f3 == 3'd7) c.alu_op = rv_decode_pkg::ALU_AND;
                else if (f3 == 3'd6) c.alu_op = rv_decode_pkg::ALU_OR;
                else if (f3 == 3'd2) c.alu_op = rv_decode_pkg::ALU_SLT;
                else if (f3 == 3'd3) c.alu_op = rv_decode_pkg::ALU_SLTU;
                else ok = 1'b0;
            end
            7'b0010011: begin
                {c.rd, c.rs1, c.reg_wen} = {w[11:7], w[19:15], 1'b1};
                c.alu_src = rv_decode_pkg::SRC_IMM;
                if (f3 == 3'd0) c.alu_op = rv_decode_pkg::ALU_ADD;
                else if (f3 == 3'd3) c.alu_op = rv_decode_pkg::ALU_SLTU;
                else if (f3 == 3'd4) c.alu_op = rv_decode_pkg::ALU_XOR;
                else if (f3 == 3'd7) c.alu_op = rv_decode_pkg::ALU_AND;
                else if (f3 == 3'd1 || f3 == 3'd5) begin
                    c.imm_sel = rv_decode_pkg::IMM_SHAMT;
                    if (f3 == 3'd1) c.alu_op = rv_decode_pkg::ALU_SLL;
                    else if (w[31:26] == 6'h10) c.alu_op = rv_decode_pkg::ALU_SRA;
                    else c.alu_op = rv_decode_pkg::ALU_SRL;
                    ok = (w[31:26] == 6'h00) || (f3 == 3'd5 && w[31:26] == 6'h10);
                end else ok = 1'b0;
            end
            7'b0111011: begin                   // addw, sllw
                {c.rd, c.rs1, c.rs2, c.reg_wen, c.word_op} =
                    {w[11:7], w[19:15], w[24:20], 2'b11};
                if (f3 == 3'd1) c.alu_op = rv_decode_pkg::ALU_SLLW;
                ok = (f7 == 7'h00) && (f3 == 3'd0 || f3 == 3'd1);
            end
            7'b0011011: begin                   // addiw
                {c.rd, c.rs1, c.reg_wen, c.word_op} = {w[11:7], w[19:15], 2'b11};
                c.alu_src = rv_decode_pkg::SRC_IMM;
                ok        = (f3 == 3'd0);
            end
            7'b0000011: begin
                {c.rd, c.rs1, c.reg_wen} = {w[11:7], w[19:15], 1'b1};
                c.alu_src = rv_decode_pkg::SRC_IMM;
                if (f3 == 3'd2) c.wb_sel = rv_decode_pkg::WB_LOAD_W;
                else if (f3 == 3'd3) c.wb_sel = rv_decode_pkg::WB_LOAD_D;
                else if (f3 == 3'd4) c.wb_sel = rv_decode_pkg::WB_LOAD_BU;
                else ok = 1'b0;
            end
            7'b0100011: begin
                {c.rs1, c.rs2, c.store} = {w[19:15], w[24:20], 1'b1};
                c.alu_src    = rv_decode_pkg::SRC_IMM;
                c.imm_sel    = rv_decode_pkg::IMM_S;
                c.store_mask = 8'hff >> (8 - (1 << f3[1:0]));   // 1, 2, 4 or 8 bytes
                ok           = !f3[2];
            end
            7'b1101111: begin
                {c.rd, c.reg_wen, c.jump} = {w[11:7], 2'b11};
                c.alu_src = rv_decode_pkg::SRC_FOUR_PC;
                c.imm_sel = rv_decode_pkg::IMM_J;
            end
            7'b1100111: begin
                {c.rd, c.rs1, c.reg_wen, c.jump, c.jalr} = {w[11:7], w[19:15], 3'b111};
                c.alu_src = rv_decode_pkg::SRC_FOUR_PC;
                ok        = (f3 == 3'd0);
            end
            7'b0110111, 7'b0010111: begin       // lui, auipc
                {c.rd, c.reg_wen} = {w[11:7], 1'b1};
                c.imm_sel = rv_decode_pkg::IMM_U;
                if (w[5]) begin
                    c.alu_src = rv_decode_pkg::SRC_IMM;
                    c.wb_sel  = rv_decode_pkg::WB_IMM;
                end else c.alu_src = rv_decode_pkg::SRC_IMM_PC;
            end
            7'b1100011: begin
                {c.rs1, c.rs2, c.branch} = {w[19:15], w[24:20], 1'b1};
                c.imm_sel = rv_decode_pkg::IMM_B;
                if (f3 == 3'd0) c.alu_op = rv_decode_pkg::ALU_BEQ;
                else if (f3 == 3'd1) c.alu_op = rv_decode_pkg::ALU_BNE;
                else if (f3 == 3'd4) c.alu_op = rv_decode_pkg::ALU_BLT;
                else if (f3 == 3'd5) c.alu_op = rv_decode_pkg::ALU_BGE;
                else if (f3 == 3'd6) c.alu_op = rv_decode_pkg::ALU_BLTU;
                else if (f3 == 3'd7) c.alu_op = rv_decode_pkg::ALU_BGEU;
                else ok = 1'b0;
            end
            7'b1110011: begin
                ok       = (w == `RV_EBREAK_WORD);
                c.ebreak = ok;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            c         = '0;
            c.inst    = w;
            c.illegal = 1'b1;
        end
        return c;
    endfunction

    task automatic make_legal(output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [5:0]  up6;
        r  = $random(seed);
        r2 = $random(seed);
        case (r[3:0] % 11)
            0: begin
                f3 = op_f3_list[r2[7:0] % 5];
                w  = {(f3 == 3'd0 && r2[8]) ? 7'h20 : 7'h00, r[18:14], r[13:9], f3,
                      r[8:4], 7'b0110011};
            end
            1: begin
                f3  = imm_f3_list[r2[7:0] % 6];
                up6 = r2[31:26];
                if (f3 == 3'd1) up6 = 6'h00;
                if (f3 == 3'd5) up6 = r2[8] ? 6'h10 : 6'h00;
                w   = {up6, r2[25:20], r[13:9], f3, r[8:4], 7'b0010011};
            end
            2:  w = {7'h00, r[18:14], r[13:9], 2'b00, r2[0], r[8:4], 7'b0111011};
            3:  w = {r2[31:20], r[13:9], 3'd0, r[8:4], 7'b0011011};
            4:  w = {r2[31:20], r[13:9], ld_f3_list[r2[7:0] % 3], r[8:4], 7'b0000011};
            5:  w = {r2[31:25], r[18:14], r[13:9], 1'b0, r2[1:0], r2[11:7], 7'b0100011};
            6:  w = {r2[31:12], r[8:4], 7'b1101111};
            7:  w = {r2[31:20], r[13:9], 3'd0, r[8:4], 7'b1100111};
            8:  w = {r2[31:12], r[8:4], 7'b0110111};
            9:  w = {r2[31:12], r[8:4], 7'b0010111};
            default: w = {r2[31:25], r[18:14], r[13:9], br_f3_list[r2[7:0] % 6],
                          r2[11:7], 7'b1100011};
        endcase
    endtask

    task automatic make_illegal(output logic [31:0] w);
        logic [31:0] r;
        r = $random(seed);
        case (r[31:28] % 7)
            0: w = {7'h01, r[24:20], r[19:15], r[14:12], r[11:7], 7'b0110011};  // M ops
            1: w = {7'h01, r[24:20], r[19:15], r[14:12], r[11:7], 7'b0111011};  // mulw etc
            2: w = {r[31:15], 3'd0, r[11:7], 7'b0001111};                        // fence
            3: w = {r[31:15], 3'd1, r[11:7], 7'b0000011};                        // lh
            4: w = {r[31:15], 1'b1, r[13:12], r[11:7], 7'b0100011};
            5: w = {r[31:15], 2'b01, r[12], r[11:7], 7'b1100011};
            default: w = {r[31:15], 3'd1, r[11:7], 7'b1110011};                 // csrrw
        endcase
    endtask

    task automatic check_resp(input rv_decode_pkg::axil_resp_e exp);
        if (bresp !== exp) begin
            $display("MISMATCH at %0t: bresp got %0d expected %0d", $time, bresp, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_wready(input logic exp);
        if (wready !== exp) begin
            $display("MISMATCH at %0t: wready got %b expected %b", $time, wready, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_ctrl(input rv_decode_pkg::decoded_ctrl_t exp);
        if (dec_ctrl !== exp) begin
            $display("MISMATCH at %0t: decode of %h got %h expected %h",
                     $time, exp.inst, dec_ctrl, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic do_write(input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] r;
        r = $random(seed);
        @(posedge clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= r[7:0];
        wdata   <= data;
        wstrb   <= strb;
        do begin
            @(posedge clk);
            check_wready(awready);      // AW and W are taken in the same cycle
        end while (!awready);
        if (strb == 4'hf) expected_q.push_back(ref_decode(data));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        do @(posedge clk); while (!bvalid);
        check_resp((strb == 4'hf) ? rv_decode_pkg::RESP_OKAY : rv_decode_pkg::RESP_SLVERR);
        bready  <= 1'b0;
    endtask

    // consumer side with random back-pressure and periodic long stalls
    always @(posedge clk) begin : consume
        logic [31:0] rr;
        rr = $random(seed);
        if (rst_n) begin
            if (dec_valid && dec_ready) begin
                if (expected_q.size() == 0) begin
                    $display("decoded output at %0t with no instruction outstanding", $time);
                    $display("Something failed");
                    $fatal(1);
                end else begin
                    check_ctrl(expected_q.pop_front());
                end
            end
            cycle_cnt <= cycle_cnt + 1;
            dec_ready <= ((cycle_cnt % 200) >= 40) && ((rr % 10) >= 3);
        end
    end

    initial begin
        repeat (n_writes * 20 + 200) @(posedge clk);
        $display("timeout: the run did not finish in the allowed number of cycles");
        $display("Something failed");
        $fatal(1);
    end

    initial begin : main
        logic [31:0] w;
        logic [31:0] r;
        logic [3:0]  strb;
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        dec_ready = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) begin
            @(posedge clk);
            if (bvalid || dec_valid || awready || wready) begin
                $display("outputs active after reset with no write issued");
                $display("Something failed");
                $fatal(1);
            end
        end
        for (int i = 0; i < n_writes; i++) begin
            r    = $random(seed);
            strb = 4'hf;
            if (i == 10) w = `RV_EBREAK_WORD;
            else if (r[2:0] % 5 == 0) make_illegal(w);
            else make_legal(w);
            if (i % 25 == 7) strb = (r[7:4] == 4'hf) ? 4'h7 : r[7:4];  // refused word
            do_write(w, strb);
        end
        while (expected_q.size() != 0) @(posedge clk);
        repeat (5) @(posedge clk);
        if (!dec_valid) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("decoder output still valid after all instructions were taken");
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule
